// ==== compile.f ====
hw/cpu4_pkg.sv
hw/cpu4_decoder.sv
hw/cpu4_alu.sv
hw/cpu4_regs.sv
hw/cpu4_sequencer.sv
hw/cpu4_core.sv
tests/cpu4_props.sv
tests/cpu4_tb.sv

// ==== hw/cpu4_alu.sv ====
`timescale 1ns/1ps

module cpu4_alu (
  input  cpu4_pkg::op_e    op,
  input  logic [3:0]       a,
  input  logic [3:0]       b,
  input  cpu4_pkg::flags_t flags_in,
  output logic [3:0]       result,
  output cpu4_pkg::flags_t flags_out
);

  logic [4:0] sum;

  assign sum = {1'b0, a} + {1'b0, b};

  // LD and everything outside the ALU group pass b and keep both flags
  always_comb begin
    result    = b;
    flags_out = flags_in;
    case (op)
      cpu4_pkg::op_add: begin
        result          = sum[3:0];
        flags_out.carry = sum[4];
        flags_out.zero  = (sum[3:0] == 4'h0);
      end
      cpu4_pkg::op_and, cpu4_pkg::op_fan: begin
        result         = a & b;
        flags_out.zero = ((a & b) == 4'h0);
      end
      cpu4_pkg::op_or: begin
        result         = a | b;
        flags_out.zero = ((a | b) == 4'h0);
      end
      cpu4_pkg::op_xor: begin
        result         = a ^ b;
        flags_out.zero = ((a ^ b) == 4'h0);
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hw/cpu4_core.sv ====
`timescale 1ns/1ps

module cpu4_core (
  input  logic        clk,
  input  logic        rst_n,
  output logic [11:0] rom_addr,
  input  logic [11:0] rom_data,
  output logic [7:0]  ram_addr,
  input  logic [3:0]  ram_rdata,
  output logic [3:0]  ram_wdata,
  output logic        ram_we
);

  logic [11:0]        opcode;
  logic               write_en;
  cpu4_pkg::decoded_t dec;
  cpu4_pkg::flags_t   flags;
  cpu4_pkg::flags_t   alu_flags;
  logic [3:0]         dst_val;
  logic [3:0]         src_val;
  logic [3:0]         alu_result;

  // The phase count is only looked at from inside the sequencer
  cpu4_sequencer sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec      (dec),
    .flags    (flags),
    .rom_addr (rom_addr),
    .rom_data (rom_data),
    .opcode   (opcode),
    .phase    (),
    .write_en (write_en)
  );

  cpu4_decoder decoder (
    .opcode (opcode),
    .dec    (dec)
  );

  cpu4_regs regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec        (dec),
    .write_en   (write_en),
    .ram_rdata  (ram_rdata),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .dst_val    (dst_val),
    .src_val    (src_val),
    .flags      (flags),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata),
    .ram_we     (ram_we)
  );

  cpu4_alu alu (
    .op        (dec.op),
    .a         (dst_val),
    .b         (src_val),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

endmodule

// ==== hw/cpu4_decoder.sv ====
`timescale 1ns/1ps

module cpu4_decoder (
  input  logic [11:0]        opcode,
  output cpu4_pkg::decoded_t dec
);

  logic [11:0]     ri_key;
  logic [11:0]     rq_key;
  logic [11:0]     hi_key;
  logic            ri_hit;
  logic            rq_hit;
  cpu4_pkg::op_e   ri_op;
  cpu4_pkg::op_e   rq_op;

  assign ri_key = opcode & cpu4_pkg::ri_mask;
  assign rq_key = opcode & cpu4_pkg::rq_mask;
  assign hi_key = opcode & cpu4_pkg::hi_mask;

  always_comb begin
    ri_hit = 1'b1;
    case (ri_key)
      cpu4_pkg::add_ri_base: ri_op = cpu4_pkg::op_add;
      cpu4_pkg::and_ri_base: ri_op = cpu4_pkg::op_and;
      cpu4_pkg::or_ri_base:  ri_op = cpu4_pkg::op_or;
      cpu4_pkg::xor_ri_base: ri_op = cpu4_pkg::op_xor;
      cpu4_pkg::fan_ri_base: ri_op = cpu4_pkg::op_fan;
      cpu4_pkg::ld_ri_base:  ri_op = cpu4_pkg::op_ld;
      default: begin
        ri_op  = cpu4_pkg::op_nop;
        ri_hit = 1'b0;
      end
    endcase
  end

  always_comb begin
    rq_hit = 1'b1;
    case (rq_key)
      cpu4_pkg::add_rq_base: rq_op = cpu4_pkg::op_add;
      cpu4_pkg::and_rq_base: rq_op = cpu4_pkg::op_and;
      cpu4_pkg::or_rq_base:  rq_op = cpu4_pkg::op_or;
      cpu4_pkg::xor_rq_base: rq_op = cpu4_pkg::op_xor;
      cpu4_pkg::fan_rq_base: rq_op = cpu4_pkg::op_fan;
      cpu4_pkg::ld_rq_base:  rq_op = cpu4_pkg::op_ld;
      default: begin
        rq_op  = cpu4_pkg::op_nop;
        rq_hit = 1'b0;
      end
    endcase
  end

  // The opcode ranges do not overlap, so the order here is only for clarity
  always_comb begin
    dec         = '0;
    dec.op      = cpu4_pkg::op_nop;
    dec.imm     = opcode[3:0];
    dec.target  = opcode[7:0];
    if (opcode == cpu4_pkg::nop_code) begin
      dec.op = cpu4_pkg::op_nop;
    end else if (ri_hit) begin
      dec.op      = ri_op;
      dec.dst     = cpu4_pkg::reg_sel_e'(opcode[5:4]);
      dec.src     = cpu4_pkg::reg_sel_e'(opcode[5:4]);
      dec.use_imm = 1'b1;
    end else if (rq_hit) begin
      dec.op  = rq_op;
      dec.dst = cpu4_pkg::reg_sel_e'(opcode[3:2]);
      dec.src = cpu4_pkg::reg_sel_e'(opcode[1:0]);
    end else if (hi_key == cpu4_pkg::jp_base) begin
      dec.op = cpu4_pkg::op_jp;
    end else if (hi_key == cpu4_pkg::jpc_base) begin
      dec.op = cpu4_pkg::op_jpc;
    end else if (hi_key == cpu4_pkg::jpz_base) begin
      dec.op = cpu4_pkg::op_jpz;
    end else if (hi_key == cpu4_pkg::ldx_base) begin
      dec.op = cpu4_pkg::op_ldx;
    end else if (hi_key == cpu4_pkg::ldy_base) begin
      dec.op = cpu4_pkg::op_ldy;
    end
  end

endmodule

// ==== hw/cpu4_pkg.sv ====
package cpu4_pkg;

  // Every instruction takes the same number of clocks
  localparam int num_phases = 7;
  localparam logic [2:0] latch_phase = 3'd1;
  localparam logic [2:0] write_phase = 3'd5;
  localparam logic [2:0] last_phase = 3'(num_phases - 1);

  typedef enum logic [3:0] {
    op_nop,
    op_ld,
    op_add,
    op_and,
    op_or,
    op_xor,
    op_fan,
    op_jp,
    op_jpc,
    op_jpz,
    op_ldx,
    op_ldy
  } op_e;

  // Operand code used by both the r and q fields
  typedef enum logic [1:0] {
    sel_a,
    sel_b,
    sel_mx,
    sel_my
  } reg_sel_e;

  typedef struct packed {
    op_e        op;
    reg_sel_e   dst;
    reg_sel_e   src;
    logic       use_imm;
    logic [3:0] imm;
    logic [7:0] target;
  } decoded_t;

  typedef struct packed {
    logic carry;
    logic zero;
  } flags_t;

  // Immediate forms, r in bits 5:4 and i in bits 3:0
  localparam logic [11:0] add_ri_base = 12'hC00;
  localparam logic [11:0] and_ri_base = 12'hC80;
  localparam logic [11:0] or_ri_base  = 12'hCC0;
  localparam logic [11:0] xor_ri_base = 12'hD00;
  localparam logic [11:0] fan_ri_base = 12'hD80;
  localparam logic [11:0] ld_ri_base  = 12'hE00;
  localparam logic [11:0] ri_mask     = 12'hFC0;

  // Register forms, r in bits 3:2 and q in bits 1:0
  localparam logic [11:0] add_rq_base = 12'hA80;
  localparam logic [11:0] and_rq_base = 12'hAC0;
  localparam logic [11:0] or_rq_base  = 12'hAD0;
  localparam logic [11:0] xor_rq_base = 12'hAE0;
  localparam logic [11:0] fan_rq_base = 12'hF10;
  localparam logic [11:0] ld_rq_base  = 12'hEC0;
  localparam logic [11:0] rq_mask     = 12'hFF0;

  // Eight-bit operand in the low byte
  localparam logic [11:0] jp_base  = 12'h000;
  localparam logic [11:0] jpc_base = 12'h200;
  localparam logic [11:0] jpz_base = 12'h600;
  localparam logic [11:0] ldx_base = 12'hB00;
  localparam logic [11:0] ldy_base = 12'h800;
  localparam logic [11:0] hi_mask  = 12'hF00;

  localparam logic [11:0] nop_code = 12'hFFB;

endpackage

// ==== hw/cpu4_regs.sv ====
`timescale 1ns/1ps

module cpu4_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu4_pkg::decoded_t dec,
  input  logic               write_en,
  input  logic [3:0]         ram_rdata,
  input  logic [3:0]         alu_result,
  input  cpu4_pkg::flags_t   alu_flags,
  output logic [3:0]         dst_val,
  output logic [3:0]         src_val,
  output cpu4_pkg::flags_t   flags,
  output logic [7:0]         ram_addr,
  output logic [3:0]         ram_wdata,
  output logic               ram_we
);

  logic [3:0] a;
  logic [3:0] b;
  logic [7:0] x;
  logic [7:0] y;
  logic [3:0] src_lat;
  logic       dst_mem;
  logic       src_mem;
  logic       mem_to_mem;
  logic       writes_dst;

  assign dst_mem    = (dec.dst == cpu4_pkg::sel_mx) || (dec.dst == cpu4_pkg::sel_my);
  assign src_mem    = !dec.use_imm &&
                      ((dec.src == cpu4_pkg::sel_mx) || (dec.src == cpu4_pkg::sel_my));
  assign mem_to_mem = dst_mem && src_mem;
  assign writes_dst = (dec.op == cpu4_pkg::op_ld)  || (dec.op == cpu4_pkg::op_add) ||
                      (dec.op == cpu4_pkg::op_and) || (dec.op == cpu4_pkg::op_or)  ||
                      (dec.op == cpu4_pkg::op_xor);

  // With two memory operands the source is read first and held in src_lat,
  // then the address moves to the destination for the write-back cycle
  always_comb begin
    if (dst_mem && (!mem_to_mem || write_en)) begin
      ram_addr = (dec.dst == cpu4_pkg::sel_my) ? y : x;
    end else begin
      ram_addr = (dec.src == cpu4_pkg::sel_my) ? y : x;
    end
  end

  always_comb begin
    case (dec.dst)
      cpu4_pkg::sel_a: dst_val = a;
      cpu4_pkg::sel_b: dst_val = b;
      default:         dst_val = ram_rdata;
    endcase
  end

  always_comb begin
    if (dec.use_imm) begin
      src_val = dec.imm;
    end else if (mem_to_mem) begin
      src_val = src_lat;
    end else begin
      case (dec.src)
        cpu4_pkg::sel_a: src_val = a;
        cpu4_pkg::sel_b: src_val = b;
        default:         src_val = ram_rdata;
      endcase
    end
  end

  assign ram_we    = write_en && writes_dst && dst_mem;
  assign ram_wdata = alu_result;

  always_ff @(posedge clk) begin
    if (!write_en) begin
      src_lat <= ram_rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a     <= 4'h0;
      b     <= 4'h0;
      x     <= 8'h00;
      y     <= 8'h00;
      flags <= '0;
    end else if (write_en) begin
      case (dec.op)
        cpu4_pkg::op_ldx: x <= dec.target;
        cpu4_pkg::op_ldy: y <= dec.target;
        cpu4_pkg::op_fan: flags <= alu_flags;
        cpu4_pkg::op_ld, cpu4_pkg::op_add, cpu4_pkg::op_and,
        cpu4_pkg::op_or, cpu4_pkg::op_xor: begin
          flags <= alu_flags;
          if (dec.dst == cpu4_pkg::sel_a) a <= alu_result;
          if (dec.dst == cpu4_pkg::sel_b) b <= alu_result;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== hw/cpu4_sequencer.sv ====
`timescale 1ns/1ps

module cpu4_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu4_pkg::decoded_t dec,
  input  cpu4_pkg::flags_t   flags,
  output logic [11:0]        rom_addr,
  input  logic [11:0]        rom_data,
  output logic [11:0]        opcode,
  output logic [2:0]         phase,
  output logic               write_en
);

  logic [11:0] pc;
  logic        jump_taken;

  always_comb begin
    case (dec.op)
      cpu4_pkg::op_jp:  jump_taken = 1'b1;
      cpu4_pkg::op_jpc: jump_taken = flags.carry;
      cpu4_pkg::op_jpz: jump_taken = flags.zero;
      default:          jump_taken = 1'b0;
    endcase
  end

  // PC only moves at the end of the last phase, so the fetch address
  // holds steady for the whole instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase  <= 3'd0;
      pc     <= 12'h000;
      opcode <= cpu4_pkg::nop_code;
    end else begin
      if (phase == cpu4_pkg::last_phase) begin
        phase <= 3'd0;
        if (jump_taken) begin
          pc <= {pc[11:8], dec.target};
        end else begin
          pc <= pc + 12'd1;
        end
      end else begin
        phase <= phase + 3'd1;
      end
      if (phase == cpu4_pkg::latch_phase) begin
        opcode <= rom_data;
      end
    end
  end

  assign rom_addr = pc;
  assign write_en = (phase == cpu4_pkg::write_phase);

endmodule

// ==== tests/cpu4_props.sv ====
`timescale 1ns/1ps

module cpu4_props (
  input logic        clk,
  input logic        rst_n,
  input logic [2:0]  phase,
  input logic        write_en,
  input logic [11:0] rom_addr
);

  phase_range: assert property (@(posedge clk) disable iff (!rst_n)
    phase <= cpu4_pkg::last_phase)
    else $error("phase counter went past the last phase");

  // The strobe comes five cycles after the fetch address moves and lasts one cycle
  write_after_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(rom_addr) |-> !write_en ##(cpu4_pkg::write_phase) write_en ##1 !write_en)
    else $error("write strobe not in the write-back phase of the instruction");

  // A new fetch address is first seen in phase 0, right after phase 6
  fetch_on_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(rom_addr) |-> (phase == 3'd0) && ($past(phase) == cpu4_pkg::last_phase))
    else $error("fetch address moved in the middle of an instruction");

endmodule

// ==== tests/cpu4_tb.sv ====
`timescale 1ns/1ps

module cpu4_tb;

  // Architectural state of the reference model plus the write of the last step
  typedef struct packed {
    logic [255:0][3:0] mem;
    logic [3:0]        a;
    logic [3:0]        b;
    logic [7:0]        x;
    logic [7:0]        y;
    logic              carry;
    logic              zero;
    logic [11:0]       pc;
    logic              wr_valid;
    logic [7:0]        wr_addr;
    logic [3:0]        wr_data;
  } model_t;

  logic        clk;
  logic        rst_n;
  logic [11:0] rom_addr;
  logic [11:0] rom_data;
  logic [7:0]  ram_addr;
  logic [3:0]  ram_rdata;
  logic [3:0]  ram_wdata;
  logic        ram_we;

  logic [11:0] rom [4096];
  logic [3:0]  ram [256];
  logic [31:0] lfsr;
  logic [11:0] asm_pc;
  logic [11:0] end_addr;
  logic        asm_done = 1'b0;
  logic        started = 1'b0;
  logic        done = 1'b0;
  logic        we_prev = 1'b0;
  logic [11:0] last_addr = 12'h000;
  int          cyc = 0;
  int          writes_seen = 0;
  int          checks = 0;
  int          errors = 0;
  model_t      model;

  cpu4_core uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .rom_addr  (rom_addr),
    .rom_data  (rom_data),
    .ram_addr  (ram_addr),
    .ram_rdata (ram_rdata),
    .ram_wdata (ram_wdata),
    .ram_we    (ram_we)
  );

  bind cpu4_sequencer cpu4_props props (
    .clk      (clk),
    .rst_n    (rst_n),
    .phase    (phase),
    .write_en (write_en),
    .rom_addr (rom_addr)
  );

  assign rom_data  = rom[rom_addr];
  assign ram_rdata = ram[ram_addr];

  always #20 clk = ~clk;

  always @(posedge clk) begin
    if (ram_we) begin
      ram[ram_addr] <= ram_wdata;
    end
  end

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] rand_bits(int n);
    logic [7:0] v;
    v = 8'h00;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [3:0] read_operand(model_t s, logic [1:0] sel);
    case (sel)
      2'd0:    return s.a;
      2'd1:    return s.b;
      2'd2:    return s.mem[s.x];
      default: return s.mem[s.y];
    endcase
  endfunction

  function automatic model_t ref_step(model_t s, logic [11:0] code);
    model_t        n;
    cpu4_pkg::op_e op;
    logic          imm_form;
    logic [1:0]    r;
    logic [3:0]    lhs;
    logic [3:0]    rhs;
    logic [4:0]    sum;
    logic [3:0]    res;
    logic          taken;
    n          = s;
    n.wr_valid = 1'b0;
    n.pc       = s.pc + 12'd1;
    op         = cpu4_pkg::op_nop;
    imm_form   = 1'b1;
    case (code[11:6])
      cpu4_pkg::add_ri_base[11:6]: op = cpu4_pkg::op_add;
      cpu4_pkg::and_ri_base[11:6]: op = cpu4_pkg::op_and;
      cpu4_pkg::or_ri_base[11:6]:  op = cpu4_pkg::op_or;
      cpu4_pkg::xor_ri_base[11:6]: op = cpu4_pkg::op_xor;
      cpu4_pkg::fan_ri_base[11:6]: op = cpu4_pkg::op_fan;
      cpu4_pkg::ld_ri_base[11:6]:  op = cpu4_pkg::op_ld;
      default:                     imm_form = 1'b0;
    endcase
    if (!imm_form) begin
      case (code[11:4])
        cpu4_pkg::add_rq_base[11:4]: op = cpu4_pkg::op_add;
        cpu4_pkg::and_rq_base[11:4]: op = cpu4_pkg::op_and;
        cpu4_pkg::or_rq_base[11:4]:  op = cpu4_pkg::op_or;
        cpu4_pkg::xor_rq_base[11:4]: op = cpu4_pkg::op_xor;
        cpu4_pkg::fan_rq_base[11:4]: op = cpu4_pkg::op_fan;
        cpu4_pkg::ld_rq_base[11:4]:  op = cpu4_pkg::op_ld;
        default:                     op = cpu4_pkg::op_nop;
      endcase
    end
    if (!imm_form && op == cpu4_pkg::op_nop) begin
      case (code[11:8])
        cpu4_pkg::jp_base[11:8]:  op = cpu4_pkg::op_jp;
        cpu4_pkg::jpc_base[11:8]: op = cpu4_pkg::op_jpc;
        cpu4_pkg::jpz_base[11:8]: op = cpu4_pkg::op_jpz;
        cpu4_pkg::ldx_base[11:8]: op = cpu4_pkg::op_ldx;
        cpu4_pkg::ldy_base[11:8]: op = cpu4_pkg::op_ldy;
        default:                  op = cpu4_pkg::op_nop;
      endcase
    end
    r   = imm_form ? code[5:4] : code[3:2];
    lhs = read_operand(s, r);
    rhs = imm_form ? code[3:0] : read_operand(s, code[1:0]);
    sum = {1'b0, lhs} + {1'b0, rhs};
    case (op)
      cpu4_pkg::op_add:                   res = sum[3:0];
      cpu4_pkg::op_and, cpu4_pkg::op_fan: res = lhs & rhs;
      cpu4_pkg::op_or:                    res = lhs | rhs;
      cpu4_pkg::op_xor:                   res = lhs ^ rhs;
      default:                            res = rhs;
    endcase
    if (op inside {cpu4_pkg::op_add, cpu4_pkg::op_and, cpu4_pkg::op_or, cpu4_pkg::op_xor,
                   cpu4_pkg::op_fan}) begin
      n.zero = (res == 4'h0);
    end
    if (op == cpu4_pkg::op_add) begin
      n.carry = sum[4];
    end
    // FAN only tests, so it stays out of the write-back list
    if (op inside {cpu4_pkg::op_ld, cpu4_pkg::op_add, cpu4_pkg::op_and, cpu4_pkg::op_or,
                   cpu4_pkg::op_xor}) begin
      case (r)
        2'd0: n.a = res;
        2'd1: n.b = res;
        default: begin
          n.wr_valid       = 1'b1;
          n.wr_addr        = (r == 2'd2) ? s.x : s.y;
          n.wr_data        = res;
          n.mem[n.wr_addr] = res;
        end
      endcase
    end
    if (op == cpu4_pkg::op_ldx) begin
      n.x = code[7:0];
    end
    if (op == cpu4_pkg::op_ldy) begin
      n.y = code[7:0];
    end
    taken = (op == cpu4_pkg::op_jp) || (op == cpu4_pkg::op_jpc && s.carry) ||
            (op == cpu4_pkg::op_jpz && s.zero);
    if (taken) begin
      n.pc = {s.pc[11:8], code[7:0]};
    end
    return n;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  function automatic logic [11:0] imm_code(logic [11:0] base, logic [1:0] r, logic [3:0] i);
    return base | {6'h00, r, i};
  endfunction

  function automatic logic [11:0] reg_code(logic [11:0] base, logic [1:0] r, logic [1:0] q);
    return base | {8'h00, r, q};
  endfunction

  task automatic place(input logic [11:0] code);
    rom[asm_pc] = code;
    asm_pc++;
  endtask

  // Jump over one NOP, padded so that the target never wraps within the page
  task automatic branch_over_nop(input logic [11:0] base);
    while (asm_pc[7:0] > 8'hFD) begin
      place(cpu4_pkg::nop_code);
    end
    place(base | {4'h0, asm_pc[7:0] + 8'd2});
    place(cpu4_pkg::nop_code);
  endtask

  task automatic load_random_operands();
    place(cpu4_pkg::ldx_base | {4'h0, rand_bits(8)});
    place(cpu4_pkg::ldy_base | {4'h0, rand_bits(8)});
    for (int r = 0; r < 4; r++) begin
      place(imm_code(cpu4_pkg::ld_ri_base, 2'(r), 4'(rand_bits(4))));
    end
    // Random carry and zero going into the instruction under test
    place(imm_code(cpu4_pkg::add_ri_base, 2'd0, 4'(rand_bits(4))));
  endtask

  task automatic build_program();
    logic [11:0] logic_ri [3];
    logic [11:0] logic_rq [3];
    logic_ri = '{cpu4_pkg::and_ri_base, cpu4_pkg::or_ri_base, cpu4_pkg::xor_ri_base};
    logic_rq = '{cpu4_pkg::and_rq_base, cpu4_pkg::or_rq_base, cpu4_pkg::xor_rq_base};
    asm_pc = 12'h000;
    for (int r = 0; r < 4; r++) begin
      load_random_operands();
      place(imm_code(cpu4_pkg::fan_ri_base, 2'(r), 4'(rand_bits(4))));
      branch_over_nop(cpu4_pkg::jpz_base);
      branch_over_nop(cpu4_pkg::jpc_base);
    end
    for (int p = 0; p < 16; p++) begin
      load_random_operands();
      place(reg_code(cpu4_pkg::fan_rq_base, 2'(p / 4), 2'(p % 4)));
      branch_over_nop(cpu4_pkg::jpz_base);
      branch_over_nop(cpu4_pkg::jpc_base);
    end
    for (int k = 0; k < 3; k++) begin
      for (int m = 2; m < 4; m++) begin
        load_random_operands();
        place(imm_code(logic_ri[k], 2'(m), 4'(rand_bits(4))));
        branch_over_nop(cpu4_pkg::jpz_base);
        load_random_operands();
        place(reg_code(logic_rq[k], 2'(m), 2'(rand_bits(2))));
        branch_over_nop(cpu4_pkg::jpz_base);
      end
    end
    for (int k = 0; k < 8; k++) begin
      load_random_operands();
      place(imm_code(cpu4_pkg::add_ri_base, 2'(rand_bits(2)), 4'(rand_bits(4))));
      branch_over_nop(cpu4_pkg::jpc_base);
      branch_over_nop(cpu4_pkg::jpz_base);
      place(reg_code(cpu4_pkg::add_rq_base, 2'(rand_bits(2)), 2'(rand_bits(2))));
      branch_over_nop(cpu4_pkg::jpc_base);
      branch_over_nop(cpu4_pkg::jpz_base);
    end
    for (int k = 0; k < 2; k++) begin
      load_random_operands();
      for (int p = 0; p < 16; p++) begin
        place(reg_code(cpu4_pkg::ld_rq_base, 2'(p / 4), 2'(p % 4)));
        // A register destination is only seen once it is copied out to MX
        if (p / 4 < 2) begin
          place(reg_code(cpu4_pkg::ld_rq_base, 2'd2, 2'(p / 4)));
        end
      end
      branch_over_nop(cpu4_pkg::jp_base);
    end
    // The program ends in a jump to itself
    end_addr = asm_pc;
    place(cpu4_pkg::jp_base | {4'h0, end_addr[7:0]});
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      cyc = cyc + 1;
      if (ram_we) begin
        writes_seen = writes_seen + 1;
        check(32'(cyc), 32'(cpu4_pkg::write_phase), "RAM write outside phase 5");
        check(32'(we_prev), 32'd0, "ram_we held high for more than one cycle");
        check(32'(model.wr_valid), 32'd1, "RAM write by an instruction that writes nothing");
        if (model.wr_valid) begin
          check(32'(ram_addr), 32'(model.wr_addr), "RAM write address");
          check(32'(ram_wdata), 32'(model.wr_data), "RAM write data");
        end
      end
      if (!started) begin
        model = '0;
        for (int i = 0; i < 256; i++) begin
          model.mem[i] = ram[i];
        end
      end
      if (!started || rom_addr != last_addr) begin
        if (started) begin
          check(32'(cyc), 32'(cpu4_pkg::num_phases), "cycles between fetches");
          check(32'(writes_seen), 32'(model.wr_valid), "RAM writes in one instruction");
        end
        check(32'(rom_addr), 32'(model.pc), "fetch address");
        if (rom_addr == end_addr) begin
          done = 1'b1;
        end
        model       = ref_step(model, rom[model.pc]);
        last_addr   = rom_addr;
        started     = 1'b1;
        cyc         = 0;
        writes_seen = 0;
      end
      we_prev = ram_we;
    end
  end

  initial begin
    wait (asm_done);
    #((int'(asm_pc) + 4) * cpu4_pkg::num_phases * 80);
    $display("Timeout: the core did not reach the end of the test program");
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    lfsr  = 32'h9ca0_dbad;
    for (int i = 0; i < 256; i++) begin
      ram[i] = 4'(rand_bits(4));
    end
    build_program();
    asm_done = 1'b1;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    wait (done);
    // Let the final self-jump run twice so a stray strobe shows up
    repeat (2 * cpu4_pkg::num_phases) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
